/* files.f */
logic/hispi_pkg.sv
logic/hispi_frame_decode.sv
logic/hispi_line_fifo.sv
logic/hispi_lane_serializer.sv
logic/hispi_tx_top.sv
bench/hispi_lane_rx.sv
bench/hispi_tx_tb.sv

/* Makefile */
# Verilator build and run for the HiSPi transmitter testbench

VERILATOR ?= verilator
TB_TOP    ?= hispi_tx_tb
RTL_TOP   ?= hispi_tx_top
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= run.log
PASS_MSG  ?= Test completed successfully
VFLAGS    ?= --binary --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/hispi_tx_tb.sv */
/*
 * HiSPi transmitter testbench.
 * Applies a table of frames with random pixels and checks each lane's
 * code words, data words and per-frame word counts.
 */
`default_nettype none

module hispi_tx_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import hispi_pkg::*;

    localparam int NUM_FRAMES = 4;
    localparam int TIMEOUT    = 40000;
    localparam int HBLANK_SLOTS = 48; // hact low after each line, outlasts the EOL/SOL words

    // lines, width, vact-low slots before the frame, data words per lane
    int frame_lines [NUM_FRAMES] = '{3, 1, 4, 2};
    int frame_width [NUM_FRAMES] = '{13, 8, 6, 18};
    int frame_gap   [NUM_FRAMES] = '{4, 20, 1, 1};   // last two back to back
    int frame_words [NUM_FRAMES] = '{12, 2, 8, 10};

    logic oclk = 1'b0;
    logic rst;
    pix_t pxd_i;
    logic px_en_i;
    logic vact_i;
    logic hact_i;
    logic [NUM_LANES-1:0] lane_o;
    logic [NUM_LANES-1:0] word_v;
    logic [NUM_LANES-1:0] sync_v;
    logic [NUM_LANES-1:0] bad_v;
    pix_t rx_word [NUM_LANES];
    pix_t rx_code [NUM_LANES];
    logic [12:0] exp_q [NUM_LANES][$];  // msb marks a code word
    int   data_cnt [NUM_LANES];
    int   frame_idx [NUM_LANES];
    int   eof_seen;
    logic [31:0] rng;

    always #50 oclk = ~oclk;

    hispi_tx_top dut (
        .oclk(oclk), .rst(rst), .pxd_i(pxd_i), .px_en_i(px_en_i),
        .vact_i(vact_i), .hact_i(hact_i), .lane_o(lane_o)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_rx
        hispi_lane_rx u_rx (
            .oclk(oclk), .rst(rst), .sin_i(lane_o[i]),
            .word_valid_o(word_v[i]), .word_o(rx_word[i]),
            .sync_valid_o(sync_v[i]), .code_o(rx_code[i]), .bad_idle_o(bad_v[i])
        );
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // 0 and 1 show up often; FFF and 800 stay out of the data
    function automatic pix_t pick_pixel(input logic [31:0] r);
        pix_t p;
        if (r[14:12] == 3'd0) begin
            p = 12'h000;
        end else if (r[14:12] == 3'd1) begin
            p = 12'h001;
        end else begin
            p = r[11:0];
        end
        if ((p == 12'hFFF) || (p == 12'h800)) begin
            p = p ^ 12'h001;
        end
        return p;
    endfunction

    function automatic logic [12:0] code_item(input sync_code_t code, input logic flag);
        return {1'b1, 7'b0, flag, code};
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input pix_t got, input pix_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%03h expected 0x%03h", name, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_sync(input string name, input sync_code_t got, input sync_code_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%01h expected 0x%01h", name, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_embed(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%01h expected 0x%01h", name, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // one pixel slot, px_en high in one cycle out of three
    task automatic apply_slot(input pix_t p, input logic v, input logic h);
        @(posedge oclk);
        px_en_i <= 1'b1;
        pxd_i   <= p;
        vact_i  <= v;
        hact_i  <= h;
        @(posedge oclk);
        px_en_i <= 1'b0;
        @(posedge oclk);
    endtask

    task automatic push_all(input logic [12:0] item);
        for (int k = 0; k < NUM_LANES; k++) begin
            exp_q[k].push_back(item);
        end
    endtask

    task automatic send_frame(input int lines, input int width, input int gap);
        pix_t line_pix [$];
        pix_t p;
        int   padded;
        p = pxd_i;
        padded = ((width + 3) / 4) * 4;
        for (int g = 0; g < gap; g++) begin
            apply_slot(p, 1'b0, 1'b0);
        end
        apply_slot(p, 1'b1, 1'b0);
        push_all(code_item(SYNC_SOF, EMBED_LINES > 0));
        for (int l = 0; l < lines; l++) begin
            if (l > 0) begin
                push_all(code_item(SYNC_EOL, 1'b0));
                push_all(code_item(SYNC_SOL, l < EMBED_LINES));
            end
            line_pix.delete();
            for (int i = 0; i < width; i++) begin
                rng = xorshift32(rng);
                p = pick_pixel(rng);
                apply_slot(p, 1'b1, 1'b1);
                line_pix.push_back(p);
            end
            while (line_pix.size() < padded) begin
                line_pix.push_back(p);   // pad repeats the held pixel
            end
            for (int i = 0; i < padded; i++) begin
                exp_q[i % NUM_LANES].push_back({1'b0, (line_pix[i] <= 12'h001) ? 12'h001
                                                                            : line_pix[i]});
            end
            for (int g = 0; g < HBLANK_SLOTS; g++) begin
                apply_slot(p, 1'b1, 1'b0);
            end
        end
        push_all(code_item(SYNC_EOF, 1'b0));
        apply_slot(p, 1'b0, 1'b0);
    endtask

    // receiver reports against the expected queues
    always @(posedge oclk) begin : monitor
        logic [12:0] item;
        if (!rst) begin
            for (int k = 0; k < NUM_LANES; k++) begin
                if (bad_v[k]) begin
                    abort_run($sformatf("lane %0d carried a non-idle word between frames", k));
                end
                if (word_v[k] || sync_v[k]) begin
                    if (exp_q[k].size() == 0) begin
                        abort_run($sformatf("lane %0d sent a word that was not expected", k));
                    end
                    item = exp_q[k].pop_front();
                    if (item[12] != sync_v[k]) begin
                        abort_run($sformatf("lane %0d mixed up data and sync order", k));
                    end
                    if (word_v[k]) begin
                        check_word($sformatf("lane%0d data", k), rx_word[k], item[11:0]);
                        data_cnt[k]++;
                    end else begin
                        check_sync($sformatf("lane%0d sync", k), rx_code[k][3:0], item[3:0]);
                        check_embed($sformatf("lane%0d embed", k), rx_code[k][EMBED_BIT],
                                    item[EMBED_BIT]);
                        check_word($sformatf("lane%0d code word", k), rx_code[k], item[11:0]);
                        if (item[3:0] == SYNC_SOF) begin
                            data_cnt[k] = 0;
                        end
                        if (item[3:0] == SYNC_EOF) begin
                            check_count($sformatf("lane%0d word count", k), data_cnt[k],
                                        frame_words[frame_idx[k]]);
                            frame_idx[k]++;
                            if (k == 0) begin
                                eof_seen++;
                            end
                        end
                    end
                end
            end
        end
    end

    initial begin
        int n;
        rst      = 1'b1;
        pxd_i    = '0;
        px_en_i  = 1'b0;
        vact_i   = 1'b0;
        hact_i   = 1'b0;
        eof_seen = 0;
        rng      = 32'h1239_96f6;
        for (int k = 0; k < NUM_LANES; k++) begin
            data_cnt[k]  = 0;
            frame_idx[k] = 0;
        end
        repeat (2) @(posedge oclk);
        rst <= 1'b0;

        for (int f = 0; f < NUM_FRAMES; f++) begin
            send_frame(frame_lines[f], frame_width[f], frame_gap[f]);
        end

        n = 0;
        while (eof_seen < NUM_FRAMES) begin
            @(posedge oclk);
            n++;
            if (n > TIMEOUT) begin
                abort_run("timed out waiting for the last EOF on lane 0");
            end
        end
        n = 0;
        while ((exp_q[0].size() + exp_q[1].size() + exp_q[2].size() + exp_q[3].size()) != 0) begin
            @(posedge oclk);
            n++;
            if (n > TIMEOUT) begin
                abort_run("timed out waiting for all lanes to finish the last frame");
            end
        end
        repeat (200) @(posedge oclk);  // lanes must stay idle after the last frame
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/hispi_lane_rx.sv */
/*
 * HiSPi lane receiver model.
 * Aligns on the 0xFFF, 0, 0 preamble, then reports every code word and
 * the data words of a line, and flags non-idle words between frames.
 */
`default_nettype none

module hispi_lane_rx (
    input  logic            oclk,
    input  logic            rst,
    input  logic            sin_i,
    output logic            word_valid_o,
    output hispi_pkg::pix_t word_o,
    output logic            sync_valid_o,
    output hispi_pkg::pix_t code_o,
    output logic            bad_idle_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import hispi_pkg::*;

    logic [35:0] win;        // last 36 bits, oldest in bit 0
    logic        aligned;
    bit_cnt_t    bcnt;
    pix_t        wbuf;
    logic [1:0]  rx_st;      // 0 scan, 1 after FFF, 2 after FFF 0, 3 code next
    logic        in_line;
    logic        in_frame;

    always @(posedge oclk) begin : rx_proc
        pix_t w;
        w = {sin_i, wbuf[WORD_BITS-1:1]};
        word_valid_o <= 1'b0;
        sync_valid_o <= 1'b0;
        bad_idle_o   <= 1'b0;
        if (rst) begin
            win      <= '0;
            aligned  <= 1'b0;
            bcnt     <= '0;
            rx_st    <= 2'd0;
            in_line  <= 1'b0;
            in_frame <= 1'b0;
        end else begin
            win  <= {sin_i, win[35:1]};
            wbuf <= w;
            if (!aligned) begin
                if ({sin_i, win[35:1]} === 36'h000_000_FFF) begin
                    aligned <= 1'b1;
                    bcnt    <= '0;
                    rx_st   <= 2'd3;
                end
            end else if (bcnt != bit_cnt_t'(WORD_BITS - 1)) begin
                bcnt <= bcnt + 1'b1;
            end else begin
                bcnt <= '0;
                case (rx_st)
                    2'd3: begin
                        sync_valid_o <= 1'b1;
                        code_o       <= w;
                        in_line      <= (w[3:0] == SYNC_SOF) || (w[3:0] == SYNC_SOL);
                        in_frame     <= (w[3:0] != SYNC_EOF);
                        rx_st        <= 2'd0;
                    end
                    2'd2: rx_st <= (w == 12'h000) ? 2'd3 : 2'd0;
                    2'd1: rx_st <= (w == 12'h000) ? 2'd2 : 2'd0;
                    default: begin
                        if (w == 12'hFFF) begin
                            rx_st <= 2'd1;
                        end else if (in_line && (w != 12'h000) && (w != IDLE_WORD)) begin
                            word_valid_o <= 1'b1;
                            word_o       <= w;
                        end else if (!in_frame && (w != IDLE_WORD)) begin
                            bad_idle_o <= 1'b1;
                        end
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* logic/hispi_tx_top.sv */
/*
 * HiSPi packetized-SP transmitter, four lanes.
 * Frame decoder feeds the line FIFO, which feeds four lockstep lane serializers.
 */
`default_nettype none

module hispi_tx_top (
    input  logic                          oclk,
    input  logic                          rst,
    input  hispi_pkg::pix_t               pxd_i,
    input  logic                          px_en_i,
    input  logic                          vact_i,
    input  logic                          hact_i,
    output logic [hispi_pkg::NUM_LANES-1:0] lane_o
);
    import hispi_pkg::*;

    logic        wr_en;
    fifo_entry_t wr_entry;
    logic        line_ready;
    logic        frame_start;
    fifo_entry_t entry;
    logic        dav;
    logic        line_avail;
    logic        rdy;          // from lane 0, lanes run in lockstep
    logic        sof_sol_sent;

    hispi_frame_decode u_decode (
        .oclk          (oclk),
        .rst           (rst),
        .pxd_i         (pxd_i),
        .px_en_i       (px_en_i),
        .vact_i        (vact_i),
        .hact_i        (hact_i),
        .wr_en_o       (wr_en),
        .wr_entry_o    (wr_entry),
        .line_ready_o  (line_ready),
        .frame_start_o (frame_start)
    );

    hispi_line_fifo u_fifo (
        .oclk           (oclk),
        .rst            (rst),
        .wr_en_i        (wr_en),
        .wr_entry_i     (wr_entry),
        .line_ready_i   (line_ready),
        .frame_start_i  (frame_start),
        .rdy_i          (rdy),
        .sof_sol_sent_i (sof_sol_sent),
        .entry_o        (entry),
        .dav_o          (dav),
        .line_avail_o   (line_avail)
    );

    generate
        for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
            if (i == 0) begin : g_lead
                hispi_lane_serializer u_lane (
                    .oclk           (oclk),
                    .rst            (rst),
                    .din_i          ({entry[GROUP_BITS], entry[i*WORD_BITS +: WORD_BITS]}),
                    .dav_i          (dav),
                    .line_avail_i   (line_avail),
                    .rdy_o          (rdy),
                    .sof_sol_sent_o (sof_sol_sent),
                    .sout_o         (lane_o[i])
                );
            end else begin : g_follow
                hispi_lane_serializer u_lane (
                    .oclk           (oclk),
                    .rst            (rst),
                    .din_i          ({entry[GROUP_BITS], entry[i*WORD_BITS +: WORD_BITS]}),
                    .dav_i          (dav),
                    .line_avail_i   (line_avail),
                    .rdy_o          (),
                    .sof_sol_sent_o (),
                    .sout_o         (lane_o[i])
                );
            end
        end
    endgenerate

endmodule

`default_nettype wire

/* logic/hispi_lane_serializer.sv */
/*
 * HiSPi lane serializer.
 * Takes one 12-bit slot per FIFO entry, expands sync entries into their
 * word sequences and shifts every word out lsb first, idle words when empty.
 */
`default_nettype none

module hispi_lane_serializer (
    input  logic                        oclk,
    input  logic                        rst,
    input  logic [hispi_pkg::WORD_BITS:0] din_i,
    input  logic                        dav_i,
    input  logic                        line_avail_i,
    output logic                        rdy_o,
    output logic                        sof_sol_sent_o,
    output logic                        sout_o
);
    import hispi_pkg::*;

    lane_state_t state;
    lane_state_t take_state;
    seq_step_t   step;
    seq_step_t   step_next;
    seq_step_t   last_step;
    bit_cnt_t    bit_cnt;
    pix_t        next_word;  // word staged for the next boundary
    pix_t        sr;
    logic        embed;
    logic        word_tick;
    logic        take;
    logic        is_sync;
    logic        in_seq;
    logic        paused;
    logic        advance;
    sync_code_t  din_code;
    pix_t        din_filt;

    // word at position idx of the sync sequence run by st
    function automatic pix_t seq_word(input lane_state_t st, input seq_step_t idx,
                                      input logic emb);
        pix_t w;
        w = '0;
        if ((st == LS_SYNC_SOF) || (st == LS_SYNC_EOF)) begin
            if (idx == '0) begin
                w = SYNC_PREAMBLE;
            end else if (idx == SEQ_SHORT_LAST) begin
                w = (st == LS_SYNC_SOF) ? code_word(SYNC_SOF, emb) : code_word(SYNC_EOF, 1'b0);
            end
        end else begin
            // leading zero, then EOL group, then SOL group
            if ((idx == 4'd1) || (idx == SEQ_PAUSE_STEP)) begin
                w = SYNC_PREAMBLE;
            end else if (idx == SEQ_EOL_STEP) begin
                w = code_word(SYNC_EOL, 1'b0);
            end else if (idx == SEQ_LONG_LAST) begin
                w = code_word(SYNC_SOL, emb);
            end
        end
        return w;
    endfunction

    assign word_tick = (bit_cnt == '0);
    assign rdy_o     = (state == LS_IDLE);
    assign take      = dav_i && rdy_o;
    assign is_sync   = din_i[WORD_BITS];
    assign din_code  = din_i[3:0];
    assign din_filt  = (din_i[WORD_BITS-1:1] == '0) ? pix_t'(1) : din_i[WORD_BITS-1:0];

    assign in_seq    = (state == LS_SYNC_SOF) || (state == LS_SYNC_EOF) ||
                       (state == LS_SYNC_EOL_SOL);
    assign paused    = (state == LS_PAUSE) && !line_avail_i;
    assign step_next = step + 1'b1;
    assign last_step = (state == LS_SYNC_EOL_SOL) ? SEQ_LONG_LAST : SEQ_SHORT_LAST;
    assign advance   = word_tick && ((in_seq && (step != last_step)) ||
                                     ((state == LS_PAUSE) && line_avail_i));

    always_comb begin
        if (!is_sync) begin
            take_state = LS_DATA;
        end else if (din_code == SYNC_SOF) begin
            take_state = LS_SYNC_SOF;
        end else if (din_code == SYNC_SOL) begin
            take_state = LS_SYNC_EOL_SOL; // SOL entry also closes the previous line
        end else begin
            take_state = LS_SYNC_EOF;
        end
    end

    always_ff @(posedge oclk) begin
        if (rst) begin
            bit_cnt        <= '0;
            state          <= LS_IDLE;
            step           <= '0;
            embed          <= 1'b0;
            sof_sol_sent_o <= 1'b0;
            sr             <= IDLE_WORD;
            sout_o         <= 1'b0;
        end else begin
            bit_cnt <= (bit_cnt == bit_cnt_t'(WORD_BITS - 1)) ? '0 : bit_cnt + 1'b1;

            if (word_tick) begin
                sr <= (rdy_o || paused) ? IDLE_WORD : next_word;
            end else begin
                sr <= {1'b0, sr[WORD_BITS-1:1]}; // lsb first
            end
            sout_o <= sr[0];

            sof_sol_sent_o <= advance && (step_next == last_step) &&
                              ((state == LS_SYNC_SOF) || (state == LS_SYNC_EOL_SOL));

            if (take) begin
                state <= take_state;
                step  <= '0;
                if (is_sync) begin
                    embed <= din_i[EMBED_BIT];
                end
            end else if (advance) begin
                step <= step_next;
                if (state == LS_PAUSE) begin
                    state <= LS_SYNC_EOL_SOL;
                end else if ((state == LS_SYNC_EOL_SOL) && (step_next == SEQ_PAUSE_STEP)) begin
                    state <= LS_PAUSE; // hold before the SOL group
                end
            end else if (word_tick && (state != LS_PAUSE)) begin
                state <= LS_IDLE; // data word or last code word went out
            end
        end
    end

    // staged word
    always_ff @(posedge oclk) begin
        if (take) begin
            next_word <= is_sync ? seq_word(take_state, '0, din_i[EMBED_BIT]) : din_filt;
        end else if (advance) begin
            next_word <= seq_word(state, step_next, embed);
        end
    end

endmodule

`default_nettype wire

/* logic/hispi_line_fifo.sv */
/*
 * HiSPi line FIFO and output scheduler.
 * Stores data and marker entries and counts complete lines and open frames.
 * A line is released to the lanes only once it is fully buffered.
 */
`default_nettype none

module hispi_line_fifo (
    input  logic                   oclk,
    input  logic                   rst,
    input  logic                   wr_en_i,
    input  hispi_pkg::fifo_entry_t wr_entry_i,
    input  logic                   line_ready_i,
    input  logic                   frame_start_i,
    input  logic                   rdy_i,
    input  logic                   sof_sol_sent_i,
    output hispi_pkg::fifo_entry_t entry_o,
    output logic                   dav_o,
    output logic                   line_avail_o
);
    import hispi_pkg::*;

    fifo_entry_t fifo_ram [FIFO_DEPTH];
    fifo_addr_t  wr_ptr;
    fifo_addr_t  rd_ptr;
    logic [1:0]  lines_cnt;    // complete lines not yet started on the lanes
    logic [1:0]  frames_open;  // frames begun at input, EOF not yet taken
    logic        head_sync;
    sync_code_t  head_code;
    logic        head_start;
    logic        fifo_empty;
    logic        pop;
    logic        eof_pop;

    assign entry_o    = fifo_ram[rd_ptr];
    assign head_sync  = entry_o[GROUP_BITS];
    assign head_code  = entry_o[3:0]; // same code in every lane slot
    assign head_start = head_sync && ((head_code == SYNC_SOF) || (head_code == SYNC_SOL));
    assign fifo_empty = (rd_ptr == wr_ptr);

    assign line_avail_o = (lines_cnt != 2'd0);
    // hold a line start until the whole line is in the FIFO
    assign dav_o = (frames_open != 2'd0) && !fifo_empty && !(head_start && !line_avail_o);

    assign pop     = dav_o && rdy_i;
    assign eof_pop = pop && head_sync && (head_code == SYNC_EOF);

    always_ff @(posedge oclk) begin
        if (rst) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            lines_cnt   <= 2'd0;
            frames_open <= 2'd0;
        end else begin
            if (wr_en_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            case ({line_ready_i, sof_sol_sent_i})
                2'b10:   lines_cnt <= lines_cnt + 2'd1;
                2'b01:   lines_cnt <= lines_cnt - 2'd1;
                default: lines_cnt <= lines_cnt; // both or neither
            endcase

            case ({frame_start_i, eof_pop})
                2'b10:   frames_open <= frames_open + 2'd1;
                2'b01:   frames_open <= frames_open - 2'd1;
                default: frames_open <= frames_open;
            endcase
        end
    end

    // entry storage
    always_ff @(posedge oclk) begin
        if (wr_en_i) begin
            fifo_ram[wr_ptr] <= wr_entry_i;
        end
    end

endmodule

`default_nettype wire

/* logic/hispi_frame_decode.sv */
/*
 * HiSPi frame decoder.
 * Pads lines to groups of 4 pixels, packs each group into a FIFO entry and
 * writes SOF, SOL and EOF marker entries. vact/hact are sampled on px_en
 * cycles, and hact must drop at least one pixel before vact does.
 */
`default_nettype none

module hispi_frame_decode (
    input  logic                   oclk,
    input  logic                   rst,
    input  hispi_pkg::pix_t        pxd_i,
    input  logic                   px_en_i,
    input  logic                   vact_i,
    input  logic                   hact_i,
    output logic                   wr_en_o,
    output hispi_pkg::fifo_entry_t wr_entry_o,
    output logic                   line_ready_o,
    output logic                   frame_start_o
);
    import hispi_pkg::*;

    logic       vact_d;
    logic       hact_d;
    lane_idx_t  pix_cnt;     // position inside the current group
    logic       hact_ext;
    logic       sof_pending;
    embed_cnt_t embed_cnt;   // embedded lines still to come
    logic       embed_flag;
    pix_group_t pix_group;
    logic       we_data;
    logic       we_start;
    logic       we_eof;
    logic       we_any;
    pix_t       start_word;
    pix_t       eof_word;

    assign hact_ext   = hact_i || (pix_cnt != '0); // stretch to a full group
    assign embed_flag = (embed_cnt != '0);

    assign we_eof   = vact_d && !vact_i;
    assign we_start = vact_d && hact_ext && !hact_d;
    assign we_data  = vact_d && hact_d && (pix_cnt == '0);
    assign we_any   = we_eof || we_start || we_data;

    assign start_word = code_word(sof_pending ? SYNC_SOF : SYNC_SOL, embed_flag);
    assign eof_word   = code_word(SYNC_EOF, 1'b0);

    always_ff @(posedge oclk) begin
        if (rst) begin
            vact_d        <= 1'b0;
            hact_d        <= 1'b0;
            pix_cnt       <= '0;
            sof_pending   <= 1'b1;
            embed_cnt     <= embed_cnt_t'(EMBED_LINES);
            wr_en_o       <= 1'b0;
            line_ready_o  <= 1'b0;
            frame_start_o <= 1'b0;
        end else begin
            wr_en_o       <= px_en_i && we_any;
            // previous line complete at next SOL or at EOF
            line_ready_o  <= px_en_i && (we_eof || (we_start && !sof_pending));
            frame_start_o <= px_en_i && we_start && sof_pending;

            if (px_en_i) begin
                vact_d <= vact_i;
                hact_d <= hact_ext;
                if (!vact_i) begin
                    pix_cnt     <= '0;
                    sof_pending <= 1'b1;
                    embed_cnt   <= embed_cnt_t'(EMBED_LINES);
                end else begin
                    if (hact_ext) begin
                        pix_cnt <= pix_cnt + 1'b1;
                    end
                    if (hact_d) begin
                        sof_pending <= 1'b0;
                    end
                    if (hact_d && !hact_ext && embed_flag) begin
                        embed_cnt <= embed_cnt - 1'b1; // end of an embedded line
                    end
                end
            end
        end
    end

    // pixel group and entry payload
    always_ff @(posedge oclk) begin
        if (px_en_i) begin
            pix_group <= {pxd_i, pix_group[GROUP_BITS-1:WORD_BITS]}; // lane 0 ends up low
            if (we_data) begin
                wr_entry_o <= {1'b0, pix_group};
            end else if (we_start) begin
                wr_entry_o <= {1'b1, {NUM_LANES{start_word}}};
            end else if (we_eof) begin
                wr_entry_o <= {1'b1, {NUM_LANES{eof_word}}};
            end
        end
    end

endmodule

`default_nettype wire

/* logic/hispi_pkg.sv */
/*
 * HiSPi packetized-SP transmitter definitions.
 * Widths, entry layout, sync codes, the lane sequencer states and the
 * word positions inside each sync sequence.
 */
`default_nettype none

package hispi_pkg;

    localparam int WORD_BITS     = 12;
    localparam int NUM_LANES     = 4;
    localparam int GROUP_BITS    = NUM_LANES * WORD_BITS; // one pixel per lane
    localparam int EMBED_LINES   = 2;                      // leading embedded lines per frame
    localparam int EMBED_BIT     = 4;                      // embedded flag inside a code word
    localparam int FIFO_LOGDEPTH = 9;
    localparam int FIFO_DEPTH    = 1 << FIFO_LOGDEPTH;

    typedef logic [WORD_BITS-1:0]               pix_t;
    typedef logic [3:0]                         sync_code_t;
    typedef logic [GROUP_BITS-1:0]              pix_group_t;
    typedef logic [GROUP_BITS:0]                fifo_entry_t;  // msb set for sync entries
    typedef logic [FIFO_LOGDEPTH-1:0]           fifo_addr_t;
    typedef logic [$clog2(NUM_LANES)-1:0]       lane_idx_t;
    typedef logic [$clog2(WORD_BITS)-1:0]       bit_cnt_t;
    typedef logic [$clog2(EMBED_LINES + 2)-1:0] embed_cnt_t;
    typedef logic [3:0]                         seq_step_t;

    typedef enum logic [2:0] {
        LS_IDLE,
        LS_DATA,
        LS_SYNC_SOF,
        LS_SYNC_EOF,
        LS_SYNC_EOL_SOL,
        LS_PAUSE
    } lane_state_t;

    localparam sync_code_t SYNC_SOF = 4'd3;
    localparam sync_code_t SYNC_SOL = 4'd1;
    localparam sync_code_t SYNC_EOF = 4'd7;
    localparam sync_code_t SYNC_EOL = 4'd6;

    localparam pix_t IDLE_WORD     = 12'h800;
    localparam pix_t SYNC_PREAMBLE = 12'hFFF;

    // word index inside a sync sequence
    localparam seq_step_t SEQ_SHORT_LAST = 4'd3; // code word of SOF / EOF
    localparam seq_step_t SEQ_EOL_STEP   = 4'd4;
    localparam seq_step_t SEQ_PAUSE_STEP = 4'd5; // SOL group starts here
    localparam seq_step_t SEQ_LONG_LAST  = 4'd8; // SOL code word

    function automatic pix_t code_word(input sync_code_t code, input logic embed);
        pix_t w;
        w = pix_t'(code);
        w[EMBED_BIT] = embed;
        return w;
    endfunction

endpackage

`default_nettype wire
